//--- source/noc_params.svh
// NoC input port parameters

`ifndef NOC_PARAMS_SVH
`define NOC_PARAMS_SVH

// --------------------
// Virtual channels
// --------------------

// Number of virtual channels on the input link.
`define NOC_N_VC      4

// Bits needed to carry a channel number.
`define NOC_VC_W      2

// --------------------
// Flits and packets
// --------------------

// Queue depth of each channel, in flits.
`define NOC_FLIT_BUFF 4

// Payload bits per flit.
`define NOC_DATA_W    32

// Packet size of a head flit that is a whole packet.
`define NOC_MIN_PKT   1

`endif

//--- source/noc_pkg.sv
// NoC flit types
`default_nettype none

`include "noc_params.svh"

package noc_pkg;

  // --------------------
  // Flit encoding
  // --------------------

  typedef enum logic [1:0] {
    FLIT_HEAD = 2'd0,  // Opens a packet.
    FLIT_BODY = 2'd1,  // Middle of a packet.
    FLIT_TAIL = 2'd2   // Closes a packet.
  } flit_type_e;

  typedef struct packed {
    logic [3:0]  pkt_size;  // Flits in packet, head included.
    logic [7:0]  dest;      // Destination node.
    logic [19:0] spare;     // Free for the user.
  } head_data_t;

  typedef struct packed {
    flit_type_e              type_f;  // Position in packet.
    logic [`NOC_DATA_W-1:0]  data;    // Head layout on head flits.
  } flit_t;

  // --------------------
  // Packet boundaries
  // --------------------

  // Head of a packet that still has flits to follow.
  function automatic logic opens_packet(flit_t f);
    head_data_t hd;
    hd = f.data;
    return (f.type_f == FLIT_HEAD) && (hd.pkt_size != 4'(`NOC_MIN_PKT));
  endfunction

  // Last flit of a packet, tail or lone head.
  function automatic logic closes_packet(flit_t f);
    head_data_t hd;
    hd = f.data;
    return (f.type_f == FLIT_TAIL) ||
           ((f.type_f == FLIT_HEAD) && (hd.pkt_size == 4'(`NOC_MIN_PKT)));
  endfunction

endpackage

`default_nettype wire

//--- source/flit_fifo.sv
// Flit FIFO
`timescale 1ns/1ns
`default_nettype none

module flit_fifo #(
  parameter int SLOTS = 4
) (
  input  wire                   clk,
  input  wire                   arst,
  input  wire                   write_i,   // Push data_i.
  input  wire                   read_i,    // Pop data_o.
  input  wire  noc_pkg::flit_t  data_i,
  output noc_pkg::flit_t        data_o,    // Oldest flit.
  output logic                  full_o,
  output logic                  empty_o,
  output logic                  error_o    // Push on full or pop on empty.
);

  localparam int PTR_W = (SLOTS > 1) ? $clog2(SLOTS) : 1;
  localparam int CNT_W = $clog2(SLOTS + 1);

  noc_pkg::flit_t    mem_q [SLOTS];  // Circular storage.
  logic [PTR_W-1:0]  wr_ptr_q;       // Next slot to write.
  logic [PTR_W-1:0]  rd_ptr_q;       // Oldest slot.
  logic [CNT_W-1:0]  count_q;        // Occupancy.
  logic              error_q;
  logic              wr_en;
  logic              rd_en;

  // Step a pointer with wrap at SLOTS.
  function automatic logic [PTR_W-1:0] bump(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(SLOTS - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full_o  = (count_q == CNT_W'(SLOTS));
  assign empty_o = (count_q == '0);
  assign wr_en   = write_i && !full_o;  // Drop illegal pushes.
  assign rd_en   = read_i && !empty_o;  // Drop illegal pops.
  assign data_o  = mem_q[rd_ptr_q];     // Show-ahead output.
  assign error_o = error_q;

  // --------------------
  // Storage
  // --------------------

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // --------------------
  // Pointers and count
  // --------------------

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      error_q  <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= bump(wr_ptr_q);
      end
      if (rd_en) begin
        rd_ptr_q <= bump(rd_ptr_q);
      end
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;  // Push only.
        2'b01:   count_q <= count_q - 1'b1;  // Pop only.
        default: count_q <= count_q;         // Both or neither.
      endcase
      error_q <= (write_i && full_o) || (read_i && empty_o);  // One-cycle flag.
    end
  end

endmodule

`default_nettype wire

//--- source/vc_buffer.sv
// Virtual channel buffer
`timescale 1ns/1ns
`default_nettype none

`include "noc_params.svh"

module vc_buffer (
  input  wire                   clk,
  input  wire                   arst,
  // From the input link.
  input  wire  noc_pkg::flit_t  fdata_i,
  input  wire                   valid_i,
  output logic                  ready_o,
  // Toward the arbiter.
  output noc_pkg::flit_t        fdata_o,
  output logic                  valid_o,
  input  wire                   ready_i
);

  logic  fifo_full;
  logic  fifo_empty;
  logic  lock_q;        // A multi-flit packet is still open.
  logic  head_blocked;  // New head while a packet is open.
  logic  accept;        // Flit enters the queue.
  logic  pop;           // Flit leaves toward the arbiter.

  flit_fifo #(
    .SLOTS (`NOC_FLIT_BUFF)
  ) u_fifo (
    .clk     (clk),
    .arst    (arst),
    .write_i (accept),
    .read_i  (pop),
    .data_i  (fdata_i),
    .data_o  (fdata_o),
    .full_o  (fifo_full),
    .empty_o (fifo_empty),
    .error_o ()
  );

  // --------------------
  // Handshakes
  // --------------------

  assign head_blocked = lock_q && (fdata_i.type_f == noc_pkg::FLIT_HEAD);
  assign ready_o      = !fifo_full && !head_blocked;
  assign accept       = valid_i && ready_o;
  assign valid_o      = !fifo_empty;  // Queue head is on offer.
  assign pop          = valid_o && ready_i;

  // --------------------
  // Packet lock
  // --------------------

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      lock_q <= 1'b0;
    end else if (accept) begin
      if (noc_pkg::opens_packet(fdata_i)) begin
        lock_q <= 1'b1;  // Head of a long packet.
      end else if (fdata_i.type_f == noc_pkg::FLIT_TAIL) begin
        lock_q <= 1'b0;  // Packet fully buffered.
      end
    end
  end

endmodule

`default_nettype wire

//--- source/vc_arbiter.sv
// Round-robin output arbiter
`timescale 1ns/1ns
`default_nettype none

`include "noc_params.svh"

module vc_arbiter (
  input  wire                   clk,
  input  wire                   arst,
  // From the channel buffers.
  input  wire  [`NOC_N_VC-1:0]  req_valid_i,
  input  wire  noc_pkg::flit_t  req_flit_i [`NOC_N_VC],
  output logic [`NOC_N_VC-1:0]  req_ready_o,  // At most one bit high.
  // Shared output link.
  output noc_pkg::flit_t        fdata_o,
  output logic [`NOC_VC_W-1:0]  vc_id_o,
  output logic                  valid_o,
  input  wire                   ready_i
);

  logic [`NOC_VC_W-1:0]  rr_ptr_q;   // First channel to look at.
  logic                  lock_q;     // Grant pinned to one channel.
  logic [`NOC_VC_W-1:0]  lock_vc_q;  // The pinned channel.
  logic [`NOC_VC_W-1:0]  grant_vc;
  logic                  grant_ok;
  logic                  xfer;

  // --------------------
  // Grant
  // --------------------

  always_comb begin
    int idx;
    grant_vc = rr_ptr_q;
    grant_ok = 1'b0;
    idx      = 0;
    if (lock_q) begin
      grant_vc = lock_vc_q;             // Finish the open packet.
      grant_ok = req_valid_i[lock_vc_q];
    end else begin
      for (int i = 0; i < `NOC_N_VC; i++) begin
        idx = (int'(rr_ptr_q) + i) % `NOC_N_VC;  // Scan from the pointer.
        if (!grant_ok && req_valid_i[idx]) begin
          grant_vc = idx[`NOC_VC_W-1:0];
          grant_ok = 1'b1;
        end
      end
    end
  end

  assign fdata_o = req_flit_i[grant_vc];
  assign vc_id_o = grant_vc;
  assign valid_o = grant_ok;
  assign xfer    = grant_ok && ready_i;

  always_comb begin
    req_ready_o = '0;
    req_ready_o[grant_vc] = xfer;  // Pop only the granted queue.
  end

  // --------------------
  // Pointer and lock
  // --------------------

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      rr_ptr_q  <= '0;
      lock_q    <= 1'b0;
      lock_vc_q <= '0;
    end else if (xfer) begin
      if (noc_pkg::opens_packet(fdata_o)) begin
        lock_q    <= 1'b1;  // Hold until the tail leaves.
        lock_vc_q <= grant_vc;
      end else if (noc_pkg::closes_packet(fdata_o)) begin
        lock_q   <= 1'b0;
        rr_ptr_q <= (grant_vc == `NOC_VC_W'(`NOC_N_VC - 1)) ? '0 : grant_vc + 1'b1;
      end
    end else if (grant_ok) begin
      // Stalled offer stays put so a late request cannot steal it.
      lock_q    <= 1'b1;
      lock_vc_q <= grant_vc;
    end
  end

endmodule

`default_nettype wire

//--- source/noc_input_port.sv
// NoC router input port
`timescale 1ns/1ns
`default_nettype none

`include "noc_params.svh"

module noc_input_port (
  input  wire                   clk,
  input  wire                   arst,
  // Input link.
  input  wire  [`NOC_VC_W-1:0]  vc_id_i,   // Target channel of fdata_i.
  input  wire  noc_pkg::flit_t  fdata_i,
  input  wire                   valid_i,
  output logic [`NOC_N_VC-1:0]  ready_o,   // One bit per channel.
  // Output link to the switch.
  output noc_pkg::flit_t        fdata_o,
  output logic [`NOC_VC_W-1:0]  vc_id_o,
  output logic                  valid_o,
  input  wire                   ready_i
);

  logic [`NOC_N_VC-1:0]  vc_valid_in;  // Steered input valids.
  logic [`NOC_N_VC-1:0]  vc_valid;     // Buffer heads on offer.
  logic [`NOC_N_VC-1:0]  vc_ready;     // Grants from the arbiter.
  noc_pkg::flit_t        vc_flit [`NOC_N_VC];

  // --------------------
  // Channel buffers
  // --------------------

  for (genvar v = 0; v < `NOC_N_VC; v++) begin : g_vc
    // Only the addressed channel sees the valid.
    assign vc_valid_in[v] = valid_i && (vc_id_i == `NOC_VC_W'(v));

    vc_buffer u_vc (
      .clk     (clk),
      .arst    (arst),
      .fdata_i (fdata_i),
      .valid_i (vc_valid_in[v]),
      .ready_o (ready_o[v]),
      .fdata_o (vc_flit[v]),
      .valid_o (vc_valid[v]),
      .ready_i (vc_ready[v])
    );
  end

  // --------------------
  // Output arbiter
  // --------------------

  vc_arbiter u_arb (
    .clk         (clk),
    .arst        (arst),
    .req_valid_i (vc_valid),
    .req_flit_i  (vc_flit),
    .req_ready_o (vc_ready),
    .fdata_o     (fdata_o),
    .vc_id_o     (vc_id_o),
    .valid_o     (valid_o),
    .ready_i     (ready_i)
  );

endmodule

`default_nettype wire

//--- tests/noc_input_port_properties.sv
// Output link assertions
`timescale 1ns/1ns
`default_nettype none

`include "noc_params.svh"

module noc_input_port_properties (
  input wire                   clk,
  input wire                   arst,
  input wire  [`NOC_N_VC-1:0]  ready_o,
  input wire  noc_pkg::flit_t  fdata_o,
  input wire  [`NOC_VC_W-1:0]  vc_id_o,
  input wire                   valid_o,
  input wire                   ready_i
);

  noc_pkg::head_data_t   hd;
  logic                  open_q;     // Multi-flit packet on the link.
  logic [`NOC_VC_W-1:0]  open_vc_q;  // Its channel.

  assign hd = fdata_o.data;

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      open_q    <= 1'b0;
      open_vc_q <= '0;
    end else if (valid_o && ready_i) begin
      if (fdata_o.type_f == noc_pkg::FLIT_HEAD && hd.pkt_size != 4'(`NOC_MIN_PKT)) begin
        open_q    <= 1'b1;
        open_vc_q <= vc_id_o;
      end else if (fdata_o.type_f == noc_pkg::FLIT_TAIL) begin
        open_q    <= 1'b0;
      end
    end
  end

  // --------------------
  // Properties
  // --------------------

  a_hold_on_stall: assert property (@(posedge clk) disable iff (arst)
    valid_o && !ready_i |=> valid_o && $stable(fdata_o) && $stable(vc_id_o))
    else $error("Output flit changed under back-pressure");

  a_inside_packet: assert property (@(posedge clk) disable iff (arst)
    valid_o && open_q |-> fdata_o.type_f != noc_pkg::FLIT_HEAD && vc_id_o == open_vc_q)
    else $error("Head or foreign channel inside an open packet");

  a_between_packets: assert property (@(posedge clk) disable iff (arst)
    valid_o && !open_q |-> fdata_o.type_f == noc_pkg::FLIT_HEAD)
    else $error("Packet does not start with a head flit");

  a_after_reset: assert property (@(posedge clk)
    $fell(arst) |-> ready_o == '1 && !valid_o)
    else $error("Port not idle after reset");

endmodule

`default_nettype wire

//--- tests/tb_noc_input_port.sv
// NoC input port testbench
`timescale 1ns/1ns
`default_nettype none

`include "noc_params.svh"

module tb_noc_input_port;

  localparam int CLK_PERIOD   = 8;
  localparam int SAMPLE_DELAY = CLK_PERIOD / 2 - 1;  // Just before the rising edge.
  localparam int RESET_CYCLES = 16;
  localparam int TOTAL_FLITS  = 31;                  // Flits over all tests.
  localparam int MAX_STALL    = 16;                  // Worst cycles spent per flit.
  localparam int CYCLE_LIMIT  = RESET_CYCLES + TOTAL_FLITS * MAX_STALL;

  logic                  clk;
  logic                  arst;
  logic [`NOC_VC_W-1:0]  vc_id_i;
  noc_pkg::flit_t        fdata_i;
  logic                  valid_i;
  logic [`NOC_N_VC-1:0]  ready_o;
  noc_pkg::flit_t        fdata_o;
  logic [`NOC_VC_W-1:0]  vc_id_o;
  logic                  valid_o;
  logic                  ready_i;

  logic [31:0]           lfsr_q;                  // Stimulus LFSR state.
  logic                  stall_en;                // Random back-pressure.
  int                    cycles = 0;
  int                    errors;
  int                    tests_run;
  int                    tests_failed;
  int                    out_count;               // Flits seen leaving.
  logic                  out_open;                // Output packet still open.
  logic [`NOC_VC_W-1:0]  out_vc;                  // Its channel.
  int                    xfer_cyc [$];            // Cycles of output transfers.
  noc_pkg::flit_t        exp_q  [`NOC_N_VC][$];   // Accepted, not yet out.
  noc_pkg::flit_t        pend_q [`NOC_N_VC][$];   // Built, not yet sent.

  noc_input_port dut0 (
    .clk     (clk),
    .arst    (arst),
    .vc_id_i (vc_id_i),
    .fdata_i (fdata_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .fdata_o (fdata_o),
    .vc_id_o (vc_id_o),
    .valid_o (valid_o),
    .ready_i (ready_i)
  );

  bind noc_input_port noc_input_port_properties u_props (
    .clk     (clk),
    .arst    (arst),
    .ready_o (ready_o),
    .fdata_o (fdata_o),
    .vc_id_o (vc_id_o),
    .valid_o (valid_o),
    .ready_i (ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("Run stopped at cycle %0d, the DUT did not move all flits in time", cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // --------------------
  // Stimulus helpers
  // --------------------

  // Taps 32, 22, 2, 1.
  function automatic logic rand_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], rand_bit()};  // One step per bit.
    end
    return v;
  endfunction

  // Head, size-2 bodies, tail; a size-1 packet is a lone head.
  task automatic build_packet(input int vc, input int size);
    noc_pkg::head_data_t hd;
    noc_pkg::flit_t      f;
    hd.pkt_size = 4'(size);
    hd.dest     = 8'(rand_bits(8));
    hd.spare    = 20'(rand_bits(20));
    f.type_f    = noc_pkg::FLIT_HEAD;
    f.data      = hd;
    pend_q[vc].push_back(f);
    for (int i = 1; i < size; i++) begin
      f.type_f = (i == size - 1) ? noc_pkg::FLIT_TAIL : noc_pkg::FLIT_BODY;
      f.data   = rand_bits(32);
      pend_q[vc].push_back(f);
    end
  endtask

  // Offer one flit for one cycle; starts and ends on a falling edge.
  task automatic try_flit(input logic [`NOC_VC_W-1:0] vc, input noc_pkg::flit_t f,
                          output logic taken);
    vc_id_i = vc;
    fdata_i = f;
    valid_i = 1'b1;
    #(SAMPLE_DELAY);
    taken = ready_o[vc];  // Moves at the coming edge.
    if (taken) begin
      exp_q[vc].push_back(f);
    end
    @(negedge clk);
  endtask

  task automatic send_flit(input logic [`NOC_VC_W-1:0] vc, input noc_pkg::flit_t f);
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      try_flit(vc, f, taken);
    end
  endtask

  task automatic send_pending(input int vc);
    while (pend_q[vc].size() != 0) begin
      send_flit(`NOC_VC_W'(vc), pend_q[vc].pop_front());
    end
  endtask

  task automatic wait_drain();
    int left;
    left = 1;
    while (left != 0) begin
      @(negedge clk);
      left = 0;
      for (int v = 0; v < `NOC_N_VC; v++) begin
        left += exp_q[v].size();
      end
    end
  endtask

  task automatic drive_stalls();
    logic active;
    forever begin
      @(posedge clk);
      active = stall_en;  // Latched away from the driving edge.
      @(negedge clk);
      if (active) begin
        ready_i = rand_bit();
      end
    end
  endtask

  // --------------------
  // Checks
  // --------------------

  task automatic check_flit(input string name, input noc_pkg::flit_t got,
                            input noc_pkg::flit_t want);
    if (got !== want) begin
      $display("ERROR %s got %h expected %h", name, got, want);
      errors++;
    end
  endtask

  task automatic check_vc(input string name, input logic [`NOC_VC_W-1:0] got,
                          input logic [`NOC_VC_W-1:0] want);
    if (got !== want) begin
      $display("ERROR %s got %h expected %h", name, got, want);
      errors++;
    end
  endtask

  task automatic check_ready(input string name, input logic [`NOC_N_VC-1:0] got,
                             input logic [`NOC_N_VC-1:0] want);
    if (got !== want) begin
      $display("ERROR %s got %h expected %h", name, got, want);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("ERROR %s got %h expected %h", name, got, want);
      errors++;
    end
  endtask

  task automatic check_count(input string what, input int got, input int want);
    if (got != want) begin
      $display("Saw %0d %s where %0d were sent", got, what, want);
      errors++;
    end
  endtask

  // Sampled just before each rising edge.
  task automatic monitor_output();
    noc_pkg::head_data_t hd;
    noc_pkg::flit_t      want;
    forever begin
      @(negedge clk);
      #(SAMPLE_DELAY);
      if (!arst && valid_o && ready_i) begin
        hd = fdata_o.data;
        if (exp_q[vc_id_o].size() == 0) begin
          $display("Flit %h left on channel %0d where none was waiting", fdata_o, vc_id_o);
          errors++;
        end else begin
          want = exp_q[vc_id_o].pop_front();
          check_flit("fdata_o", fdata_o, want);
        end
        if (out_open) begin
          check_vc("vc_id_o", vc_id_o, out_vc);  // No interleaving.
        end
        if (fdata_o.type_f == noc_pkg::FLIT_HEAD && hd.pkt_size != 4'(`NOC_MIN_PKT)) begin
          out_open = 1'b1;
          out_vc   = vc_id_o;
        end else if (fdata_o.type_f == noc_pkg::FLIT_TAIL) begin
          out_open = 1'b0;
        end
        out_count++;
        xfer_cyc.push_back(cycles);
      end
    end
  endtask

  task automatic finish_test(input string name, input int start_errors);
    tests_run++;
    if (errors == start_errors) begin
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors", name, errors - start_errors);
    end
  endtask

  // --------------------
  // Tests
  // --------------------

  task automatic test_reset_state();
    int e0;
    e0 = errors;
    check_bit("valid_o", valid_o, 1'b0);
    check_ready("ready_o", ready_o, '1);
    finish_test("reset state", e0);
  endtask

  task automatic test_single_flits();
    int e0;
    e0 = errors;
    for (int v = 0; v < `NOC_N_VC; v++) begin
      build_packet(v, 1);
      send_pending(v);
    end
    valid_i = 1'b0;
    wait_drain();
    finish_test("single flits", e0);
  endtask

  task automatic test_long_packet();
    int e0;
    e0 = errors;
    xfer_cyc.delete();
    build_packet(3, 5);
    send_pending(3);
    valid_i = 1'b0;
    wait_drain();
    check_count("transfers", xfer_cyc.size(), 5);
    if (xfer_cyc.size() == 5 && xfer_cyc[4] - xfer_cyc[0] != 4) begin
      $display("Five-flit packet spread over %0d cycles", xfer_cyc[4] - xfer_cyc[0] + 1);
      errors++;
    end
    finish_test("long packet", e0);
  endtask

  task automatic test_interleaved();
    int e0;
    int n0;
    e0 = errors;
    n0 = out_count;
    build_packet(0, 2);
    build_packet(1, 3);
    build_packet(2, 4);
    build_packet(3, 3);
    for (int r = 0; r < 4; r++) begin
      for (int v = 0; v < `NOC_N_VC; v++) begin
        if (pend_q[v].size() != 0) begin
          send_flit(`NOC_VC_W'(v), pend_q[v].pop_front());  // One flit per channel per round.
        end
      end
    end
    valid_i = 1'b0;
    wait_drain();
    check_count("flits", out_count - n0, 12);
    finish_test("interleaved", e0);
  endtask

  task automatic test_backpressure();
    int e0;
    e0 = errors;
    ready_i = 1'b0;
    build_packet(1, 6);
    for (int i = 0; i < `NOC_FLIT_BUFF; i++) begin
      send_flit(2'd1, pend_q[1].pop_front());
    end
    valid_i = 1'b0;
    @(negedge clk);
    check_bit("ready_o[1]", ready_o[1], 1'b0);  // Queue is full.
    check_bit("valid_o", valid_o, 1'b1);
    stall_en = 1'b1;
    send_pending(1);
    valid_i = 1'b0;
    wait_drain();
    stall_en = 1'b0;
    @(negedge clk);  // Stall driver goes idle.
    ready_i  = 1'b1;
    finish_test("back-pressure", e0);
  endtask

  task automatic test_head_lock();
    int             e0;
    logic           taken;
    noc_pkg::flit_t lone;
    e0 = errors;
    build_packet(2, 3);
    build_packet(2, 1);
    lone = pend_q[2][3];
    send_flit(2'd2, pend_q[2].pop_front());
    for (int i = 0; i < 2; i++) begin
      try_flit(2'd2, lone, taken);
      if (taken) begin
        $display("Second head accepted on channel 2 while a packet was open");
        errors++;
      end
    end
    send_pending(2);  // Body, tail, then the lone head.
    valid_i = 1'b0;
    wait_drain();
    finish_test("head lock", e0);
  endtask

  initial begin
    lfsr_q       = 32'h15299d08;
    stall_en     = 1'b0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    out_count    = 0;
    out_open     = 1'b0;
    out_vc       = '0;
    arst         = 1'b1;
    vc_id_i      = '0;
    fdata_i      = '0;
    valid_i      = 1'b0;
    ready_i      = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    arst = 1'b0;
    fork
      monitor_output();
      drive_stalls();
    join_none
    test_reset_state();
    test_single_flits();
    test_long_packet();
    test_interleaved();
    test_backpressure();
    test_head_lock();
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+source
source/noc_pkg.sv
source/flit_fifo.sv
source/vc_buffer.sv
source/vc_arbiter.sv
source/noc_input_port.sv
tests/noc_input_port_properties.sv
tests/tb_noc_input_port.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_noc_input_port
FLIST    = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = TESTBENCH FAILED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
